//--- hdl/crtc_cpu_if.sv
// ======================================================================
// CPU-side register write strobes of the CRT controller
// Driven from the top-level pins, read by the register block
// ======================================================================
`timescale 1ns/100ps

interface crtc_cpu_if;
    import crtc_pkg::*;

    logic                  clk_en;      // Character clock enable
    logic [DATA_WIDTH-1:0] data;        // Write data from CPU
    logic                  cs;          // Chip select
    logic                  we;          // Write strobe
    logic                  rs;          // 0 = address register, 1 = data register

    modport reg_side (
        input clk_en, data, cs, we, rs
    );

endinterface

//--- hdl/crtc_pkg.sv
// ======================================================================
// Shared definitions for the 6545/6845-style CRT controller
// Bus widths, register indices and the vertical phase of the timing
// generator. Modules import this package inside their bodies and use
// scoped names in their port lists
// ======================================================================
package crtc_pkg;

    localparam int DATA_WIDTH      = 8;     // CPU and Wishbone data bus
    localparam int WB_ADDR_WIDTH   = 16;    // Wishbone address bus
    localparam int CRTC_ADDR_WIDTH = 5;     // Register address in R0..R31 space
    localparam int CRTC_REG_COUNT  = 18;    // R0..R17 are stored

    localparam int MA_WIDTH = 14;           // Refresh memory address
    localparam int RA_WIDTH = 5;            // Raster (scan line) address

    // Register indices with a function in this design
    typedef enum logic [CRTC_ADDR_WIDTH-1:0] {
        CRTC_R0_H_TOTAL        = 5'd0,      // Characters per line minus one
        CRTC_R1_H_DISPLAYED    = 5'd1,      // Visible characters per line
        CRTC_R2_H_SYNC_POS     = 5'd2,      // HSYNC start character
        CRTC_R3_SYNC_WIDTH     = 5'd3,      // VSYNC width [7:4], HSYNC width [3:0]
        CRTC_R4_V_TOTAL        = 5'd4,      // Rows per frame minus one
        CRTC_R5_V_ADJUST       = 5'd5,      // Extra scan lines after last row
        CRTC_R6_V_DISPLAYED    = 5'd6,      // Visible rows
        CRTC_R7_V_SYNC_POS     = 5'd7,      // VSYNC start row
        CRTC_R9_MAX_SCAN_LINE  = 5'd9,      // Scan lines per row minus one
        CRTC_R12_START_ADDR_HI = 5'd12,     // Start address bits 13:8
        CRTC_R13_START_ADDR_LO = 5'd13      // Start address bits 7:0
    } crtc_reg_e;

    // Vertical phase of the frame
    typedef enum logic {
        VPH_ROWS   = 1'b0,                  // Counting character rows
        VPH_ADJUST = 1'b1                   // Running the R5 adjust lines
    } crtc_vphase_e;

endpackage

//--- hdl/crtc_timing_if.sv
// ======================================================================
// Decoded register fields passed from the register block to the
// timing generator. The register block drives every field through
// the source modport; the timing generator only reads them
// ======================================================================
`timescale 1ns/100ps

interface crtc_timing_if;
    import crtc_pkg::*;

    logic [7:0]          h_total;        // R0
    logic [7:0]          h_displayed;    // R1
    logic [7:0]          h_sync_pos;     // R2
    logic [3:0]          h_sync_width;   // R3[3:0]
    logic [4:0]          v_sync_width;   // R3[7:4] where 0 means 16 lines
    logic [6:0]          v_total;        // R4
    logic [4:0]          v_adjust;       // R5
    logic [6:0]          v_displayed;    // R6
    logic [6:0]          v_sync_pos;     // R7
    logic [RA_WIDTH-1:0] max_scan_line;  // R9
    logic [MA_WIDTH-1:0] start_addr;     // R12[5:0] above R13

    modport source (
        output h_total, h_displayed, h_sync_pos, h_sync_width, v_sync_width,
               v_total, v_adjust, v_displayed, v_sync_pos, max_scan_line, start_addr
    );

    modport sink (
        input h_total, h_displayed, h_sync_pos, h_sync_width, v_sync_width,
              v_total, v_adjust, v_displayed, v_sync_pos, max_scan_line, start_addr
    );

endinterface

//--- hdl/video_crtc.sv
// ======================================================================
// CRT controller top level
// Plain CPU, Wishbone and video pins; bundles the CPU strobes into an
// interface and links the register block to the timing generator
// ======================================================================
`timescale 1ns/100ps

module video_crtc #(
    parameter logic [crtc_pkg::WB_ADDR_WIDTH-1:0] WB_CRTC_BASE = 16'h8800,
    parameter bit POWER_ON_15KHZ = 1'b0                  // 1 = 40-column 60 Hz table
) (
    input  logic                               wb_clock_i,
    input  logic                               rst_n_i,
    input  logic [crtc_pkg::WB_ADDR_WIDTH-1:0] wb_addr_i,
    output logic [crtc_pkg::DATA_WIDTH-1:0]    wb_data_o,
    input  logic                               wb_we_i,
    input  logic                               wb_cycle_i,
    input  logic                               wb_strobe_i,
    output logic                               wb_stall_o,
    output logic                               wb_ack_o,
    input  logic                               clk_en_i,    // Character clock enable
    input  logic [crtc_pkg::DATA_WIDTH-1:0]    data_i,      // CPU write data
    input  logic                               cs_i,
    input  logic                               we_i,
    input  logic                               rs_i,        // 0 = address, 1 = data
    output logic                               hsync_o,
    output logic                               vsync_o,
    output logic                               de_o,
    output logic [crtc_pkg::MA_WIDTH-1:0]      ma_o,
    output logic [crtc_pkg::RA_WIDTH-1:0]      ra_o
);

    crtc_cpu_if    cpu ();
    crtc_timing_if fields ();

    assign cpu.clk_en = clk_en_i;
    assign cpu.data   = data_i;
    assign cpu.cs     = cs_i;
    assign cpu.we     = we_i;
    assign cpu.rs     = rs_i;

    video_crtc_reg #(
        .WB_CRTC_BASE  (WB_CRTC_BASE),
        .POWER_ON_15KHZ(POWER_ON_15KHZ)
    ) u_reg (
        .wb_clock_i (wb_clock_i),
        .rst_n_i    (rst_n_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_o  (wb_data_o),
        .wb_we_i    (wb_we_i),
        .wb_cycle_i (wb_cycle_i),
        .wb_strobe_i(wb_strobe_i),
        .wb_stall_o (wb_stall_o),
        .wb_ack_o   (wb_ack_o),
        .cpu        (cpu.reg_side),
        .fields     (fields.source)
    );

    video_crtc_timing u_timing (
        .wb_clock_i(wb_clock_i),
        .rst_n_i   (rst_n_i),
        .fields    (fields.sink),
        .clk_en_i  (clk_en_i),
        .hsync_o   (hsync_o),
        .vsync_o   (vsync_o),
        .de_o      (de_o),
        .ma_o      (ma_o),
        .ra_o      (ra_o)
    );

endmodule

//--- hdl/video_crtc_reg.sv
// ======================================================================
// CRT controller register file
// The CPU writes R0..R17 through the address and data registers; a
// Wishbone B4 read port returns any register one cycle after the
// request. Reset reloads the power-on table chosen by POWER_ON_15KHZ
// and the decoded timing fields are registered for the generator
// ======================================================================
`timescale 1ns/100ps

module video_crtc_reg #(
    parameter logic [crtc_pkg::WB_ADDR_WIDTH-1:0] WB_CRTC_BASE = 16'h8800,
    parameter bit POWER_ON_15KHZ = 1'b0
) (
    input  logic                               wb_clock_i,
    input  logic                               rst_n_i,
    input  logic [crtc_pkg::WB_ADDR_WIDTH-1:0] wb_addr_i,    // Base match + register index
    output logic [crtc_pkg::DATA_WIDTH-1:0]    wb_data_o,    // Read data, valid with ack
    input  logic                               wb_we_i,      // Not decoded on this read-only port
    input  logic                               wb_cycle_i,
    input  logic                               wb_strobe_i,
    output logic                               wb_stall_o,
    output logic                               wb_ack_o,
    crtc_cpu_if.reg_side                       cpu,
    crtc_timing_if.source                      fields
);
    import crtc_pkg::*;

    localparam logic [CRTC_ADDR_WIDTH-1:0] LAST_REG = CRTC_ADDR_WIDTH'(CRTC_REG_COUNT - 1);
    localparam int BASE_LSB = CRTC_ADDR_WIDTH;    // Lowest address bit compared with base

    logic [CRTC_ADDR_WIDTH-1:0] ar;                    // Address register
    logic [DATA_WIDTH-1:0]      r [CRTC_REG_COUNT];    // R0..R17
    logic [CRTC_ADDR_WIDTH-1:0] wb_idx;
    logic                       wb_req;
    logic                       cpu_wr;

    // Power-on contents with unlisted registers at zero
    function automatic logic [DATA_WIDTH-1:0] reset_value(input logic [CRTC_ADDR_WIDTH-1:0] idx);
        logic [DATA_WIDTH-1:0] val;
        val = '0;
        if (POWER_ON_15KHZ) begin                      // Non-CRTC PET with 40 columns at 60 Hz
            case (idx)
                CRTC_R0_H_TOTAL:        val = 8'd63;
                CRTC_R1_H_DISPLAYED:    val = 8'd40;
                CRTC_R2_H_SYNC_POS:     val = 8'd48;
                CRTC_R3_SYNC_WIDTH:     val = 8'h51;
                CRTC_R4_V_TOTAL:        val = 8'd32;
                CRTC_R5_V_ADJUST:       val = 8'd5;
                CRTC_R6_V_DISPLAYED:    val = 8'd25;
                CRTC_R7_V_SYNC_POS:     val = 8'd28;
                CRTC_R9_MAX_SCAN_LINE:  val = 8'd7;
                CRTC_R12_START_ADDR_HI: val = 8'h10;   // TA12 set for normal video
                default:                val = '0;
            endcase
        end else begin                                 // 80-column machine
            case (idx)
                CRTC_R0_H_TOTAL:        val = 8'h31;
                CRTC_R1_H_DISPLAYED:    val = 8'h28;
                CRTC_R2_H_SYNC_POS:     val = 8'h29;
                CRTC_R3_SYNC_WIDTH:     val = 8'h0f;
                CRTC_R4_V_TOTAL:        val = 8'h20;
                CRTC_R5_V_ADJUST:       val = 8'h03;
                CRTC_R6_V_DISPLAYED:    val = 8'h19;
                CRTC_R7_V_SYNC_POS:     val = 8'h1d;
                CRTC_R9_MAX_SCAN_LINE:  val = 8'h09;
                CRTC_R12_START_ADDR_HI: val = 8'h10;
                default:                val = '0;
            endcase
        end
        return val;
    endfunction

    assign wb_idx     = wb_addr_i[CRTC_ADDR_WIDTH-1:0];
    assign wb_req     = wb_cycle_i && wb_strobe_i &&
                        (wb_addr_i[WB_ADDR_WIDTH-1:BASE_LSB] ==
                         WB_CRTC_BASE[WB_ADDR_WIDTH-1:BASE_LSB]);
    assign cpu_wr     = cpu.clk_en && cpu.cs && cpu.we;
    assign wb_stall_o = 1'b0;                          // Single-cycle answer that never stalls

    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
            ar       <= '0;
            for (int i = 0; i < CRTC_REG_COUNT; i++) begin
                r[i] <= reset_value(CRTC_ADDR_WIDTH'(i));
            end
        end else begin
            wb_ack_o <= wb_req;                        // Ack exactly one cycle after request
            if (!wb_req && cpu_wr) begin               // Wishbone request wins a collision
                if (!cpu.rs) begin
                    ar <= cpu.data[CRTC_ADDR_WIDTH-1:0];
                end else if (ar <= LAST_REG) begin     // R18..R31 not stored
                    r[ar] <= cpu.data;
                end
            end
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (wb_req) begin
            wb_data_o <= (wb_idx <= LAST_REG) ? r[wb_idx] : '0;
        end
    end

    // Field decode one cycle behind the register write
    always_ff @(posedge wb_clock_i) begin
        fields.h_total       <= r[CRTC_R0_H_TOTAL];
        fields.h_displayed   <= r[CRTC_R1_H_DISPLAYED];
        fields.h_sync_pos    <= r[CRTC_R2_H_SYNC_POS];
        fields.h_sync_width  <= r[CRTC_R3_SYNC_WIDTH][3:0];
        fields.v_sync_width  <= (r[CRTC_R3_SYNC_WIDTH][7:4] == 4'd0)
                                ? 5'd16                           // Zero selects 16 lines
                                : {1'b0, r[CRTC_R3_SYNC_WIDTH][7:4]};
        fields.v_total       <= r[CRTC_R4_V_TOTAL][6:0];
        fields.v_adjust      <= r[CRTC_R5_V_ADJUST][4:0];
        fields.v_displayed   <= r[CRTC_R6_V_DISPLAYED][6:0];
        fields.v_sync_pos    <= r[CRTC_R7_V_SYNC_POS][6:0];
        fields.max_scan_line <= r[CRTC_R9_MAX_SCAN_LINE][RA_WIDTH-1:0];
        fields.start_addr    <= {r[CRTC_R12_START_ADDR_HI][5:0], r[CRTC_R13_START_ADDR_LO]};
    end

endmodule

//--- hdl/video_crtc_timing.sv
// ======================================================================
// CRT controller timing generator
// Counts characters, scan lines and rows on each character clock
// enable and produces HSYNC, VSYNC, display enable and the refresh
// memory and raster addresses. Outputs are registered and describe
// the character counted on the enabled edge
// ======================================================================
`timescale 1ns/100ps

module video_crtc_timing (
    input  logic                          wb_clock_i,
    input  logic                          rst_n_i,
    crtc_timing_if.sink                   fields,
    input  logic                          clk_en_i,   // Character clock enable
    output logic                          hsync_o,
    output logic                          vsync_o,
    output logic                          de_o,       // Display enable
    output logic [crtc_pkg::MA_WIDTH-1:0] ma_o,       // Refresh memory address
    output logic [crtc_pkg::RA_WIDTH-1:0] ra_o        // Scan line within the row
);
    import crtc_pkg::*;

    logic [7:0]          h_cnt;      // Character within the line
    logic [RA_WIDTH-1:0] line_cnt;   // Scan line in row or adjust line
    logic [6:0]          row_cnt;    // Character row
    crtc_vphase_e        vphase;
    logic [MA_WIDTH-1:0] row_off;    // Row start relative to start_addr
    logic [3:0]          hs_cnt;     // HSYNC characters so far
    logic [4:0]          vs_cnt;     // VSYNC lines so far
    logic                h_end;
    logic                row_end;
    logic                adj_end;
    logic                vs_start;

    assign h_end    = (h_cnt == fields.h_total);
    assign row_end  = (line_cnt == fields.max_scan_line);
    assign adj_end  = (({1'b0, line_cnt} + 6'd1) >= {1'b0, fields.v_adjust});  // Last adjust line
    assign vs_start = (vphase == VPH_ROWS) && (row_cnt == fields.v_sync_pos) &&
                      (line_cnt == '0) && (h_cnt == '0);   // First char of sync row

    // Character, line and row counters
    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            h_cnt    <= '0;
            line_cnt <= '0;
            row_cnt  <= '0;
            vphase   <= VPH_ROWS;
            row_off  <= '0;
        end else if (clk_en_i) begin
            if (!h_end) begin
                h_cnt <= h_cnt + 8'd1;
            end else begin
                h_cnt <= '0;
                if (vphase == VPH_ADJUST) begin
                    if (adj_end) begin                 // Last adjust line ends the frame
                        vphase   <= VPH_ROWS;
                        line_cnt <= '0;
                        row_cnt  <= '0;
                        row_off  <= '0;
                    end else begin
                        line_cnt <= line_cnt + 1'b1;
                    end
                end else if (!row_end) begin
                    line_cnt <= line_cnt + 1'b1;
                end else begin
                    line_cnt <= '0;
                    if (row_cnt != fields.v_total) begin
                        row_cnt <= row_cnt + 7'd1;
                        row_off <= row_off + {{(MA_WIDTH-8){1'b0}}, fields.h_displayed};
                    end else if (fields.v_adjust != '0) begin
                        vphase <= VPH_ADJUST;          // Row count stays at v_total
                    end else begin
                        row_cnt <= '0;                 // No adjust lines so the frame ends
                        row_off <= '0;
                    end
                end
            end
        end
    end

    // Registered video outputs
    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            de_o    <= 1'b0;
            ma_o    <= '0;
            ra_o    <= '0;
            hs_cnt  <= '0;
            vs_cnt  <= '0;
        end else if (clk_en_i) begin
            de_o <= (vphase == VPH_ROWS) && (h_cnt < fields.h_displayed) &&
                    (row_cnt < fields.v_displayed);
            ma_o <= fields.start_addr + row_off + {{(MA_WIDTH-8){1'b0}}, h_cnt};
            ra_o <= line_cnt;

            if (hsync_o && hs_cnt == fields.h_sync_width) begin
                hsync_o <= 1'b0;
            end else if (hsync_o) begin
                hs_cnt <= hs_cnt + 4'd1;
            end
            if (h_cnt == fields.h_sync_pos && fields.h_sync_width != '0) begin
                hsync_o <= 1'b1;                       // Width 0 gives no pulse
                hs_cnt  <= 4'd1;
            end

            if (vsync_o && h_cnt == '0 && vs_cnt == fields.v_sync_width) begin
                vsync_o <= 1'b0;                       // Falls on a line boundary
            end else if (vsync_o && h_end) begin
                vs_cnt <= vs_cnt + 5'd1;
            end
            if (vs_start) begin
                vsync_o <= 1'b1;
                vs_cnt  <= '0;
            end
        end
    end

endmodule

//--- project.f
hdl/crtc_pkg.sv
hdl/crtc_cpu_if.sv
hdl/crtc_timing_if.sv
hdl/video_crtc_reg.sv
hdl/video_crtc_timing.sv
hdl/video_crtc.sv
sim/tb_clock_gen.sv
sim/video_crtc_checker.sv
sim/video_crtc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CRT controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module video_crtc_tb \
    -Mdir obj_dir -o video_crtc_tb > build.log 2>&1 \
    && ./obj_dir/video_crtc_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- sim/crtc_stimulus.txt
# W rs data cs clk_en (hex) | R wb_addr exp_data exp_ack (hex)
# M hsync_period hsync_width vsync_lines frame_lines (decimal)
R 8800 31 1
R 8801 28 1
R 8802 29 1
R 8803 0f 1
R 8804 20 1
R 8805 03 1
R 8806 19 1
R 8807 1d 1
R 8809 09 1
R 880c 10 1
R 880d 00 1
R 8820 00 0
R 9800 00 0
W 0 06 1 1
W 1 03 1 1
W 1 55 0 1
W 1 66 1 0
R 8806 03 1
W 0 07 1 1
W 1 04 1 1
W 0 04 1 1
W 1 07 1 1
W 0 05 1 1
W 1 02 1 1
W 0 09 1 1
W 1 03 1 1
W 0 00 1 1
W 1 0f 1 1
W 0 01 1 1
W 1 0a 1 1
W 0 02 1 1
W 1 0c 1 1
W 0 03 1 1
W 1 03 1 1
M 16 3 16 34
W 0 00 1 1
W 1 13 1 1
W 0 02 1 1
W 1 09 1 1
W 0 03 1 1
W 1 25 1 1
W 0 0c 1 1
W 1 02 1 1
W 0 0d 1 1
W 1 34 1 1
M 20 5 2 34
W 0 05 1 1
W 1 00 1 1
W 0 09 1 1
W 1 01 1 1
M 20 5 2 16
R 880c 02 1
R 880d 34 1

//--- sim/tb_clock_gen.sv
// ======================================================================
// Testbench clock and reset source
// 8 ns clock; active-low reset held for RESET_CYCLES rising edges
// ======================================================================
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 8
) (
    output logic wb_clock_o,
    output logic rst_n_o
);
    initial wb_clock_o = 1'b0;
    always #(PERIOD_NS / 2.0) wb_clock_o = ~wb_clock_o;

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge wb_clock_o);
        @(negedge wb_clock_o);
        rst_n_o = 1'b1;                                // Released away from the sampling edge
    end
endmodule

//--- sim/video_crtc_checker.sv
// ======================================================================
// Concurrent checks bound into the CRT controller top level
// Wishbone ack timing, stall level and VSYNC against display enable
// ======================================================================
`timescale 1ns/100ps

module video_crtc_checker #(
    parameter logic [15:0] WB_CRTC_BASE = 16'h8800
) (
    input logic        wb_clock_i,
    input logic        rst_n_i,
    input logic [15:0] wb_addr_i,
    input logic        wb_cycle_i,
    input logic        wb_strobe_i,
    input logic        wb_stall_o,
    input logic        wb_ack_o,
    input logic        vsync_o,
    input logic        de_o
);
    logic req;

    assign req = wb_cycle_i && wb_strobe_i && (wb_addr_i[15:5] == WB_CRTC_BASE[15:5]);

    stall_low: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i) !wb_stall_o)
        else $error("wishbone stall went high");
    ack_follows_req: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i) req |=> wb_ack_o)
        else $error("request not acked on the next cycle");
    ack_needs_req: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
                                    wb_ack_o |-> $past(req))
        else $error("ack without a request one cycle before");
    vsync_in_border: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
                                      $rose(vsync_o) |-> !de_o)
        else $error("vsync rose while display enable was high");
endmodule

bind video_crtc video_crtc_checker #(.WB_CRTC_BASE(WB_CRTC_BASE)) u_checker (.*);

//--- sim/video_crtc_tb.sv
// ======================================================================
// CRT controller testbench
// Runs the command lines of the stimulus file: CPU writes, Wishbone
// reads with expected data, and frame measurements. A register model
// cross-checks the expected values of the file
// ======================================================================
`timescale 1ns/100ps

module video_crtc_tb;
    logic        wb_clock_i, rst_n_i, wb_we_i, wb_cycle_i, wb_strobe_i, wb_stall_o, wb_ack_o;
    logic [15:0] wb_addr_i;
    logic [7:0]  wb_data_o, data_i;
    logic        clk_en_i, cs_i, we_i, rs_i, hsync_o, vsync_o, de_o;
    logic [13:0] ma_o;
    logic [4:0]  ra_o;

    byte     kind_q[$];                                // One entry per command line
    int      a_q[$], b_q[$], c_q[$], d_q[$];
    logic [7:0] m_regs [18];                           // Register model
    logic [4:0] m_ar;
    int      errors = 0, checks = 0, gap_left = 0;
    int      en_cnt = 0, hs_rise_at = 0, vs_rise_at = 0, vs_rises = 0;
    int      hs_period, hs_width, vs_period, vs_width, de_ma, de_ra;
    bit      hs_q, vs_q, de_q, de_pending;
    bit      wr_req = 0, wr_busy = 0, wr_rs, wr_cs, wr_en, limit_ready = 0;
    logic [7:0] wr_data;
    realtime limit_ns;

    tb_clock_gen u_clk (.wb_clock_o(wb_clock_i), .rst_n_o(rst_n_i));

    video_crtc #(.WB_CRTC_BASE(16'h8800), .POWER_ON_15KHZ(1'b0)) DUT (.*);

    // Samples the outputs of the last enabled edge, then drives the next enable
    always @(negedge wb_clock_i) begin
        if (rst_n_i && clk_en_i) begin
            en_cnt++;
            if (hsync_o && !hs_q) begin
                hs_period  = en_cnt - hs_rise_at;
                hs_rise_at = en_cnt;
            end
            if (!hsync_o && hs_q) hs_width = en_cnt - hs_rise_at;
            if (vsync_o && !vs_q) begin
                vs_period  = en_cnt - vs_rise_at;
                vs_rise_at = en_cnt;
                vs_rises++;
                de_pending = 1;
            end
            if (!vsync_o && vs_q) vs_width = en_cnt - vs_rise_at;
            if (de_o && !de_q && de_pending) begin     // First displayed char of frame
                de_ma      = ma_o;
                de_ra      = ra_o;
                de_pending = 0;
            end
            hs_q = hsync_o;
            vs_q = vsync_o;
            de_q = de_o;
        end
        if (wr_busy) begin
            cs_i    = 0;
            we_i    = 0;
            wr_busy = 0;
        end
        if (wr_req) begin                              // CPU write owns this enable slot
            cs_i     = wr_cs;
            we_i     = 1;
            rs_i     = wr_rs;
            data_i   = wr_data;
            clk_en_i = wr_en;
            wr_req   = 0;
            wr_busy  = 1;
            gap_left = 0;
        end else if (gap_left == 0) begin
            clk_en_i = 1;
            gap_left = $urandom_range(3, 0);           // Pulses 1 to 4 clocks apart
        end else begin
            clk_en_i = 0;
            gap_left--;
        end
    end

    task automatic check_value(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("error %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic reset_model();
        foreach (m_regs[i]) m_regs[i] = 8'h00;
        m_regs[0]  = 8'h31;                            // 80-column power-on table
        m_regs[1]  = 8'h28;
        m_regs[2]  = 8'h29;
        m_regs[3]  = 8'h0f;
        m_regs[4]  = 8'h20;
        m_regs[5]  = 8'h03;
        m_regs[6]  = 8'h19;
        m_regs[7]  = 8'h1d;
        m_regs[9]  = 8'h09;
        m_regs[12] = 8'h10;
        m_ar = 0;
    endtask

    function automatic int frame_enables();           // Characters per frame from the model
        return (m_regs[0] + 1) * ((m_regs[4][6:0] + 1) * (m_regs[9][4:0] + 1) + m_regs[5][4:0]);
    endfunction

    task automatic load_stimulus();
        int    fd, a, b, c, d;
        byte   k;
        string line;
        fd = $fopen("sim/crtc_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file sim/crtc_stimulus.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line[0] == "M") begin
                    void'($sscanf(line, "%c %d %d %d %d", k, a, b, c, d));
                end else begin
                    void'($sscanf(line, "%c %h %h %h %h", k, a, b, c, d));
                end
                if (k == "W" || k == "R" || k == "M") begin
                    kind_q.push_back(k);
                    a_q.push_back(a);
                    b_q.push_back(b);
                    c_q.push_back(c);
                    d_q.push_back(d);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic cpu_write(input bit rs, input logic [7:0] data, input bit cs, input bit en);
        @(posedge wb_clock_i);
        wr_rs   = rs;
        wr_data = data;
        wr_cs   = cs;
        wr_en   = en;
        wr_req  = 1;
        wait (!wr_req);
        wait (!wr_busy);
        if (cs && en) begin
            if (!rs) m_ar = data[4:0];
            else if (m_ar < 18) m_regs[m_ar] = data;
        end
    endtask

    task automatic wb_read(input logic [15:0] addr, input int exp, input bit exp_ack);
        if (exp_ack) check_value($sformatf("model R%0d", addr[4:0]), m_regs[addr[4:0]], exp);
        @(negedge wb_clock_i);
        wb_addr_i   = addr;
        wb_cycle_i  = 1;
        wb_strobe_i = 1;
        @(negedge wb_clock_i);
        check_value($sformatf("ack for %h", addr), wb_ack_o, exp_ack);
        check_value($sformatf("stall for %h", addr), wb_stall_o, 0);
        if (exp_ack) check_value($sformatf("read data %h", addr), wb_data_o, exp);
        wb_cycle_i  = 0;
        wb_strobe_i = 0;
        @(negedge wb_clock_i);
        check_value("ack after request", wb_ack_o, 0);
    endtask

    task automatic measure_frame(input int hper, input int hw, input int vsw, input int lines);
        int start;
        check_value("model hsync period", m_regs[0] + 1, hper);
        check_value("model hsync width", m_regs[3][3:0], hw);
        check_value("model vsync lines", (m_regs[3][7:4] == 0) ? 16 : m_regs[3][7:4], vsw);
        check_value("model frame lines", frame_enables() / hper, lines);
        start = vs_rises;
        while (vs_rises < start + 3) @(posedge wb_clock_i);    // Skip the frame in flight
        check_value("hsync period", hs_period, hper);
        check_value("hsync width", hs_width, hw);
        check_value("vsync lines", vs_width / hper, vsw);
        check_value("frame lines", vs_period / hper, lines);
        check_value("frame length remainder", vs_period % hper, 0);
        check_value("ma at first de", de_ma, {m_regs[12][5:0], m_regs[13]});
        check_value("ra at first de", de_ra, 0);
    endtask

    initial begin
        int max_en;
        void'($urandom(42));
        {wb_addr_i, wb_we_i, wb_cycle_i, wb_strobe_i} = '0;
        {clk_en_i, data_i, cs_i, we_i, rs_i} = '0;
        reset_model();
        max_en = frame_enables();
        load_stimulus();
        foreach (kind_q[i]) begin
            if (kind_q[i] == "M" && a_q[i] * d_q[i] > max_en) max_en = a_q[i] * d_q[i];
        end
        limit_ns    = 20.0 * max_en * 4 * 8 + kind_q.size() * 200.0;
        limit_ready = 1;
        wait (rst_n_i);
        repeat (4) @(negedge wb_clock_i);
        foreach (kind_q[i]) begin
            case (kind_q[i])
                "W":     cpu_write(a_q[i][0], b_q[i][7:0], c_q[i][0], d_q[i][0]);
                "R":     wb_read(a_q[i][15:0], b_q[i], c_q[i][0]);
                default: measure_frame(a_q[i], b_q[i], c_q[i], d_q[i]);
            endcase
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Ends the run after 20 of the longest frames at the slowest enable spacing
    initial begin
        wait (limit_ready);
        #(limit_ns);
        $display("timeout: the run did not finish within %0t ns", $time);
        $display("TEST FAIL");
        $finish;
    end
endmodule
